/* rtl/core_pkg.sv */
package core_pkg;

    localparam int xlen   = 32;  // data and address width.
    localparam int reg_aw = 5;   // default register index width.

    // instruction field positions.
    localparam int op_hi  = 31;
    localparam int op_lo  = 26;
    localparam int rd_lo  = 21;
    localparam int rj_lo  = 16;
    localparam int rk_lo  = 11;
    localparam int imm_hi = 11;
    localparam int imm_lo = 0;
    localparam int imm_w  = imm_hi - imm_lo + 1;

    typedef enum logic [5:0] {
        op_nop  = 6'h00,
        op_add  = 6'h01,
        op_sub  = 6'h02,
        op_and  = 6'h03,
        op_or   = 6'h04,
        op_addi = 6'h05,
        op_ldw  = 6'h06,
        op_ldh  = 6'h07,
        op_ldhu = 6'h08,
        op_ldb  = 6'h09,
        op_ldbu = 6'h0a,
        op_stw  = 6'h0b
    } op_e;

    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_w    = 3'd1,
        ld_h    = 3'd2,
        ld_hu   = 3'd3,
        ld_b    = 3'd4,
        ld_bu   = 3'd5
    } load_kind_e;

endpackage

/* rtl/reg_file.sv */
`timescale 1ns/1ps
module reg_file
    import core_pkg::*;
#(
    parameter int reg_aw = core_pkg::reg_aw
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic [reg_aw-1:0] raddr1,
    input  logic [reg_aw-1:0] raddr2,
    output logic [xlen-1:0]   rdata1,
    output logic [xlen-1:0]   rdata2,
    input  logic              we,
    input  logic [reg_aw-1:0] waddr,
    input  logic [xlen-1:0]   wdata
);
    localparam int depth = 32;

    logic [xlen-1:0] regs [depth];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // register 0 is hardwired to zero.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
module decode_stage
    import core_pkg::*;
#(
    parameter int reg_aw = core_pkg::reg_aw
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              inst_valid,
    input  logic [xlen-1:0]   inst_word,
    input  logic [xlen-1:0]   inst_pc,
    output logic              inst_ready,
    output logic [reg_aw-1:0] rf_raddr1,
    output logic [reg_aw-1:0] rf_raddr2,
    input  logic [xlen-1:0]   rf_rdata1,
    input  logic [xlen-1:0]   rf_rdata2,
    input  logic              es_allowin,
    output logic              ds_to_es_valid,
    output op_e               ds_op,
    output logic [xlen-1:0]   ds_src1,
    output logic [xlen-1:0]   ds_src2,
    output logic [xlen-1:0]   ds_imm,
    output logic [reg_aw-1:0] ds_dest,
    output logic [xlen-1:0]   ds_pc,
    input  logic [reg_aw-1:0] es_dest,
    input  logic              es_wr,
    input  logic [reg_aw-1:0] ms_dest,
    input  logic              ms_wr,
    input  logic [reg_aw-1:0] ws_dest,
    input  logic              ws_wr
);
    logic                    ds_valid;
    logic                    ds_ready_go;
    logic                    ds_allowin;
    logic [xlen-1:0]         ds_inst;
    logic [op_hi-op_lo:0]    opcode;
    logic [reg_aw-1:0]       rd;
    logic [reg_aw-1:0]       rj;
    logic [reg_aw-1:0]       rk;
    logic                    is_store;
    logic                    is_rtype;
    logic                    uses_rj;
    logic                    uses_r2;
    logic                    rj_hit;
    logic                    r2_hit;
    logic                    hazard;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && ds_allowin) begin
            ds_inst <= inst_word;
            ds_pc   <= inst_pc;
        end
    end

    assign opcode = ds_inst[op_hi:op_lo];
    assign rd     = ds_inst[rd_lo +: reg_aw];
    assign rj     = ds_inst[rj_lo +: reg_aw];
    assign rk     = ds_inst[rk_lo +: reg_aw];

    always_comb begin
        case (opcode)
            op_add, op_sub, op_and, op_or, op_addi,
            op_ldw, op_ldh, op_ldhu, op_ldb, op_ldbu, op_stw: ds_op = op_e'(opcode);
            default: ds_op = op_nop;  // unknown codes retire without effect.
        endcase
    end

    assign is_store = ds_op == op_stw;
    assign is_rtype = ds_op inside {op_add, op_sub, op_and, op_or};
    assign uses_rj  = ds_op != op_nop;
    assign uses_r2  = is_rtype || is_store;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = is_store ? rd : rk;  // store data comes from rd.

    // no forwarding, so any pending writer of a live source holds decode.
    assign rj_hit = uses_rj && rj != '0 &&
                    ((es_wr && es_dest == rj) || (ms_wr && ms_dest == rj) ||
                     (ws_wr && ws_dest == rj));
    assign r2_hit = uses_r2 && rf_raddr2 != '0 &&
                    ((es_wr && es_dest == rf_raddr2) || (ms_wr && ms_dest == rf_raddr2) ||
                     (ws_wr && ws_dest == rf_raddr2));
    assign hazard = rj_hit || r2_hit;

    assign ds_ready_go    = !hazard;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;
    assign inst_ready     = ds_allowin;

    assign ds_src1 = rf_rdata1;
    assign ds_src2 = rf_rdata2;
    assign ds_imm  = {{(xlen-imm_w){ds_inst[imm_hi]}}, ds_inst[imm_hi:imm_lo]};
    assign ds_dest = rd;

    // a stalled instruction is neither handed on nor replaced.
    assert property (@(posedge clk) disable iff (!resetn)
        ds_valid && hazard |=> ds_valid && $stable(ds_inst) && $stable(ds_pc))
        else $error("decode moved an instruction past a hazard");

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
module execute_stage
    import core_pkg::*;
#(
    parameter int reg_aw = core_pkg::reg_aw
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ds_to_es_valid,
    input  op_e               ds_op,
    input  logic [xlen-1:0]   ds_src1,
    input  logic [xlen-1:0]   ds_src2,
    input  logic [xlen-1:0]   ds_imm,
    input  logic [reg_aw-1:0] ds_dest,
    input  logic [xlen-1:0]   ds_pc,
    output logic              es_allowin,
    input  logic              ms_allowin,
    output logic              es_to_ms_valid,
    output logic [xlen-1:0]   es_result,
    output load_kind_e        es_load,
    output logic              es_mem_op,
    output logic [reg_aw-1:0] es_dest,
    output logic              es_wr,
    output logic [xlen-1:0]   es_pc,
    output logic              data_sram_req,
    output logic              data_sram_wr,
    output logic [xlen-1:0]   data_sram_addr,
    output logic [xlen-1:0]   data_sram_wdata,
    input  logic              data_sram_addr_ok
);
    logic            es_valid;
    logic            es_ready_go;
    op_e             es_op;
    logic [xlen-1:0] es_src1;
    logic [xlen-1:0] es_src2;
    logic [xlen-1:0] es_imm;
    logic [xlen-1:0] es_addr;
    logic            es_is_store;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_op   <= ds_op;
            es_src1 <= ds_src1;
            es_src2 <= ds_src2;
            es_imm  <= ds_imm;
            es_dest <= ds_dest;
            es_pc   <= ds_pc;
        end
    end

    assign es_addr = es_src1 + es_imm;

    always_comb begin
        case (es_op)
            op_add:  es_result = es_src1 + es_src2;
            op_sub:  es_result = es_src1 - es_src2;
            op_and:  es_result = es_src1 & es_src2;
            op_or:   es_result = es_src1 | es_src2;
            default: es_result = es_addr;  // addi and every memory op.
        endcase
    end

    always_comb begin
        case (es_op)
            op_ldw:  es_load = ld_w;
            op_ldh:  es_load = ld_h;
            op_ldhu: es_load = ld_hu;
            op_ldb:  es_load = ld_b;
            op_ldbu: es_load = ld_bu;
            default: es_load = ld_none;
        endcase
    end

    assign es_is_store = es_op == op_stw;
    assign es_mem_op   = es_load != ld_none || es_is_store;
    assign es_wr       = es_valid && !es_is_store && es_op != op_nop;

    // a memory op leaves on the edge its request is accepted.
    assign es_ready_go    = !es_mem_op || data_sram_addr_ok;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    assign data_sram_req   = es_valid && es_mem_op && ms_allowin;
    assign data_sram_wr    = es_is_store;
    assign data_sram_addr  = es_addr;
    assign data_sram_wdata = es_src2;

    // once raised, a request holds with the same address until it is taken.
    assert property (@(posedge clk) disable iff (!resetn)
        data_sram_req && !data_sram_addr_ok |=> data_sram_req && $stable(data_sram_addr))
        else $error("data request dropped before addr_ok");

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps
module mem_stage
    import core_pkg::*;
#(
    parameter int reg_aw = core_pkg::reg_aw
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              es_to_ms_valid,
    input  logic [xlen-1:0]   es_result,
    input  load_kind_e        es_load,
    input  logic              es_mem_op,
    input  logic [reg_aw-1:0] es_dest,
    input  logic              es_wr,
    input  logic [xlen-1:0]   es_pc,
    output logic              ms_allowin,
    output logic              ms_to_ws_valid,
    output logic              ms_rf_we,
    output logic [reg_aw-1:0] ms_rf_waddr,
    output logic [xlen-1:0]   ms_rf_wdata,
    output logic [xlen-1:0]   ms_pc,
    output logic [reg_aw-1:0] ms_dest,
    output logic              ms_wr,
    input  logic              data_sram_data_ok,
    input  logic [xlen-1:0]   data_sram_rdata
);
    logic            ms_valid;
    logic            ms_ready_go;
    logic [xlen-1:0] ms_alu_result;
    load_kind_e      ms_load;
    logic            ms_mem_op;
    logic            ms_gr_we;
    logic            ld_signed;
    logic [15:0]     half_sel;
    logic [7:0]      byte_sel;
    logic [xlen-1:0] half_data;
    logic [xlen-1:0] byte_data;
    logic [xlen-1:0] load_data;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_alu_result <= es_result;
            ms_load       <= es_load;
            ms_mem_op     <= es_mem_op;
            ms_gr_we      <= es_wr;
            ms_dest       <= es_dest;
            ms_pc         <= es_pc;
        end
    end

    // stores wait for data_ok as well, only loads use the data.
    assign ms_ready_go    = !ms_mem_op || data_sram_data_ok;
    assign ms_allowin     = !ms_valid || ms_ready_go;
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    assign ld_signed = ms_load == ld_h || ms_load == ld_b;
    assign half_sel  = ms_alu_result[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];
    assign byte_sel  = data_sram_rdata[{ms_alu_result[1:0], 3'b000} +: 8];
    assign half_data = {{(xlen-16){ld_signed & half_sel[15]}}, half_sel};
    assign byte_data = {{(xlen-8){ld_signed & byte_sel[7]}}, byte_sel};

    always_comb begin
        case (ms_load)
            ld_h, ld_hu: load_data = half_data;
            ld_b, ld_bu: load_data = byte_data;
            default:     load_data = data_sram_rdata;  // whole word.
        endcase
    end

    assign ms_rf_we    = ms_valid && ms_gr_we;
    assign ms_rf_waddr = ms_dest;
    assign ms_rf_wdata = (ms_load != ld_none) ? load_data : ms_alu_result;
    assign ms_wr       = ms_rf_we;

    // each data_ok answers the one request this stage is holding.
    assert property (@(posedge clk) disable iff (!resetn)
        data_sram_data_ok |-> ms_valid && ms_mem_op)
        else $error("data_ok with no memory op outstanding");

endmodule

/* rtl/result_stage.sv */
`timescale 1ns/1ps
module result_stage
    import core_pkg::*;
#(
    parameter int reg_aw = core_pkg::reg_aw
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ms_to_ws_valid,
    input  logic              ms_rf_we,
    input  logic [reg_aw-1:0] ms_rf_waddr,
    input  logic [xlen-1:0]   ms_rf_wdata,
    input  logic [xlen-1:0]   ms_pc,
    output logic              rf_we,
    output logic [reg_aw-1:0] rf_waddr,
    output logic [xlen-1:0]   rf_wdata,
    output logic [reg_aw-1:0] ws_dest,
    output logic              ws_wr,
    output logic              wb_valid,
    output logic [xlen-1:0]   wb_pc
);
    logic ws_valid;
    logic ws_rf_we;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_to_ws_valid;  // always accepts, one cycle per item.
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid) begin
            ws_rf_we <= ms_rf_we;
            rf_waddr <= ms_rf_waddr;
            rf_wdata <= ms_rf_wdata;
            wb_pc    <= ms_pc;
        end
    end

    assign rf_we    = ws_valid && ws_rf_we;
    assign ws_wr    = rf_we;
    assign ws_dest  = rf_waddr;
    assign wb_valid = ws_valid;

endmodule

/* rtl/load_store_core.sv */
`timescale 1ns/1ps
module load_store_core
    import core_pkg::*;
#(
    parameter int reg_aw = core_pkg::reg_aw
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              inst_valid,
    input  logic [xlen-1:0]   inst_word,
    input  logic [xlen-1:0]   inst_pc,
    output logic              inst_ready,
    output logic              data_sram_req,
    output logic              data_sram_wr,
    output logic [xlen-1:0]   data_sram_addr,
    output logic [xlen-1:0]   data_sram_wdata,
    input  logic              data_sram_addr_ok,
    input  logic              data_sram_data_ok,
    input  logic [xlen-1:0]   data_sram_rdata,
    output logic              wb_valid,
    output logic [xlen-1:0]   wb_pc,
    output logic              wb_rf_we,
    output logic [reg_aw-1:0] wb_rf_waddr,
    output logic [xlen-1:0]   wb_rf_wdata
);
    logic [reg_aw-1:0] rf_raddr1;
    logic [reg_aw-1:0] rf_raddr2;
    logic [xlen-1:0]   rf_rdata1;
    logic [xlen-1:0]   rf_rdata2;
    logic              es_allowin;
    logic              ds_to_es_valid;
    op_e               ds_op;
    logic [xlen-1:0]   ds_src1;
    logic [xlen-1:0]   ds_src2;
    logic [xlen-1:0]   ds_imm;
    logic [reg_aw-1:0] ds_dest;
    logic [xlen-1:0]   ds_pc;
    logic              ms_allowin;
    logic              es_to_ms_valid;
    logic [xlen-1:0]   es_result;
    load_kind_e        es_load;
    logic              es_mem_op;
    logic [reg_aw-1:0] es_dest;
    logic              es_wr;
    logic [xlen-1:0]   es_pc;
    logic              ms_to_ws_valid;
    logic              ms_rf_we;
    logic [reg_aw-1:0] ms_rf_waddr;
    logic [xlen-1:0]   ms_rf_wdata;
    logic [xlen-1:0]   ms_pc;
    logic [reg_aw-1:0] ms_dest;
    logic              ms_wr;
    logic [reg_aw-1:0] ws_dest;
    logic              ws_wr;

    reg_file #(.reg_aw(reg_aw)) reg_file_i (
        .clk, .resetn,
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(wb_rf_we), .waddr(wb_rf_waddr), .wdata(wb_rf_wdata)
    );

    decode_stage #(.reg_aw(reg_aw)) decode_stage_i (
        .clk, .resetn, .inst_valid, .inst_word, .inst_pc, .inst_ready,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .es_allowin, .ds_to_es_valid, .ds_op, .ds_src1, .ds_src2, .ds_imm,
        .ds_dest, .ds_pc,
        .es_dest, .es_wr, .ms_dest, .ms_wr, .ws_dest, .ws_wr
    );

    execute_stage #(.reg_aw(reg_aw)) execute_stage_i (
        .clk, .resetn, .ds_to_es_valid, .ds_op, .ds_src1, .ds_src2, .ds_imm,
        .ds_dest, .ds_pc, .es_allowin, .ms_allowin, .es_to_ms_valid,
        .es_result, .es_load, .es_mem_op, .es_dest, .es_wr, .es_pc,
        .data_sram_req, .data_sram_wr, .data_sram_addr, .data_sram_wdata,
        .data_sram_addr_ok
    );

    mem_stage #(.reg_aw(reg_aw)) mem_stage_i (
        .clk, .resetn, .es_to_ms_valid, .es_result, .es_load, .es_mem_op,
        .es_dest, .es_wr, .es_pc, .ms_allowin, .ms_to_ws_valid,
        .ms_rf_we, .ms_rf_waddr, .ms_rf_wdata, .ms_pc, .ms_dest, .ms_wr,
        .data_sram_data_ok, .data_sram_rdata
    );

    result_stage #(.reg_aw(reg_aw)) result_stage_i (
        .clk, .resetn, .ms_to_ws_valid, .ms_rf_we, .ms_rf_waddr, .ms_rf_wdata,
        .ms_pc, .rf_we(wb_rf_we), .rf_waddr(wb_rf_waddr), .rf_wdata(wb_rf_wdata),
        .ws_dest, .ws_wr, .wb_valid, .wb_pc
    );

endmodule

/* dv/tb_load_store_core.sv */
`timescale 1ns/1ps
module tb_load_store_core
    import core_pkg::*;
();
    logic              clk;
    logic              resetn;
    logic              inst_valid;
    logic [xlen-1:0]   inst_word;
    logic [xlen-1:0]   inst_pc;
    logic              inst_ready;
    logic              data_sram_req;
    logic              data_sram_wr;
    logic [xlen-1:0]   data_sram_addr;
    logic [xlen-1:0]   data_sram_wdata;
    logic              data_sram_addr_ok;
    logic              data_sram_data_ok;
    logic [xlen-1:0]   data_sram_rdata;
    logic              wb_valid;
    logic [xlen-1:0]   wb_pc;
    logic              wb_rf_we;
    logic [reg_aw-1:0] wb_rf_waddr;
    logic [xlen-1:0]   wb_rf_wdata;

    string             names [$];
    logic [xlen-1:0]   words [$];
    logic [xlen-1:0]   pcs [$];
    logic              exp_we [$];
    logic [reg_aw-1:0] exp_waddr [$];
    logic [xlen-1:0]   exp_wdata [$];

    logic [xlen-1:0]   sram [256];
    logic [xlen-1:0]   resp_data [$];
    int                resp_wait [$];
    int                errors = 0;
    int                n_checked = 0;

    load_store_core #(.reg_aw(reg_aw)) load_store_core_i (
        .clk, .resetn, .inst_valid, .inst_word, .inst_pc, .inst_ready,
        .data_sram_req, .data_sram_wr, .data_sram_addr, .data_sram_wdata,
        .data_sram_addr_ok, .data_sram_data_ok, .data_sram_rdata,
        .wb_valid, .wb_pc, .wb_rf_we, .wb_rf_waddr, .wb_rf_wdata
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] encode_rtype(op_e op, int rd, int rj, int rk);
        return {op, rd[4:0], rj[4:0], rk[4:0], 11'b0};
    endfunction

    function automatic logic [31:0] encode_itype(op_e op, int rd, int rj, int imm);
        return {op, rd[4:0], rj[4:0], 4'b0, imm[11:0]};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] word, input logic we,
                             input int waddr, input logic [31:0] wdata);
        pcs.push_back(32'h1c00_0000 + 4 * words.size());
        names.push_back(name);
        words.push_back(word);
        exp_we.push_back(we);
        exp_waddr.push_back(waddr[reg_aw-1:0]);
        exp_wdata.push_back(wdata);
    endtask

    // memory word 4 holds f28a7bc3, word n elsewhere holds 1357nnnn.
    task automatic build_table();
        add_entry("addi r1", encode_itype(op_addi, 1, 0, 12'h123), 1, 1, 32'h0000_0123);
        add_entry("addi r2 neg", encode_itype(op_addi, 2, 0, -5), 1, 2, 32'hffff_fffb);
        add_entry("addi r3", encode_itype(op_addi, 3, 0, 16), 1, 3, 32'h0000_0010);
        add_entry("addi r4", encode_itype(op_addi, 4, 0, 12'h7ff), 1, 4, 32'h0000_07ff);
        add_entry("add.w r5", encode_rtype(op_add, 5, 1, 2), 1, 5, 32'h0000_011e);
        add_entry("sub.w r6", encode_rtype(op_sub, 6, 1, 2), 1, 6, 32'h0000_0128);
        add_entry("and r7", encode_rtype(op_and, 7, 2, 4), 1, 7, 32'h0000_07fb);
        add_entry("or r8", encode_rtype(op_or, 8, 1, 3), 1, 8, 32'h0000_0133);
        add_entry("addi r0", encode_itype(op_addi, 0, 1, 12'h055), 1, 0, 32'h0000_0178);
        add_entry("add.w r9 r0", encode_rtype(op_add, 9, 0, 1), 1, 9, 32'h0000_0123);
        add_entry("ld.w r10", encode_itype(op_ldw, 10, 3, 0), 1, 10, 32'hf28a_7bc3);
        add_entry("ld.h r11 +0", encode_itype(op_ldh, 11, 3, 0), 1, 11, 32'h0000_7bc3);
        add_entry("ld.h r12 +2", encode_itype(op_ldh, 12, 3, 2), 1, 12, 32'hffff_f28a);
        add_entry("ld.hu r13 +2", encode_itype(op_ldhu, 13, 3, 2), 1, 13, 32'h0000_f28a);
        add_entry("ld.hu r14 +0", encode_itype(op_ldhu, 14, 3, 0), 1, 14, 32'h0000_7bc3);
        add_entry("ld.b r15 +0", encode_itype(op_ldb, 15, 3, 0), 1, 15, 32'hffff_ffc3);
        add_entry("ld.b r16 +1", encode_itype(op_ldb, 16, 3, 1), 1, 16, 32'h0000_007b);
        add_entry("ld.b r17 +2", encode_itype(op_ldb, 17, 3, 2), 1, 17, 32'hffff_ff8a);
        add_entry("ld.b r18 +3", encode_itype(op_ldb, 18, 3, 3), 1, 18, 32'hffff_fff2);
        add_entry("ld.bu r19 +0", encode_itype(op_ldbu, 19, 3, 0), 1, 19, 32'h0000_00c3);
        add_entry("ld.bu r20 +1", encode_itype(op_ldbu, 20, 3, 1), 1, 20, 32'h0000_007b);
        add_entry("ld.bu r21 +2", encode_itype(op_ldbu, 21, 3, 2), 1, 21, 32'h0000_008a);
        add_entry("ld.bu r22 +3", encode_itype(op_ldbu, 22, 3, 3), 1, 22, 32'h0000_00f2);
        add_entry("ld.w r23 fill", encode_itype(op_ldw, 23, 0, 32), 1, 23, 32'h1357_0808);
        add_entry("ld.w r31 neg", encode_itype(op_ldw, 31, 3, -12), 1, 31, 32'h1357_0101);
        add_entry("st.w r5", encode_itype(op_stw, 5, 3, 4), 0, 0, 32'h0);
        add_entry("ld.w r24 back", encode_itype(op_ldw, 24, 3, 4), 1, 24, 32'h0000_011e);
        add_entry("add.w r25 use", encode_rtype(op_add, 25, 24, 1), 1, 25, 32'h0000_0241);
        add_entry("st.w r25", encode_itype(op_stw, 25, 0, 36), 0, 0, 32'h0);
        add_entry("ld.w r26 back", encode_itype(op_ldw, 26, 0, 36), 1, 26, 32'h0000_0241);
        add_entry("sub.w r27 use", encode_rtype(op_sub, 27, 26, 10), 1, 27, 32'h0d75_867e);
        add_entry("or r28", encode_rtype(op_or, 28, 15, 16), 1, 28, 32'hffff_fffb);
        add_entry("and r29", encode_rtype(op_and, 29, 17, 4), 1, 29, 32'h0000_078a);
        add_entry("ld.bu r30 +1", encode_itype(op_ldbu, 30, 0, 37), 1, 30, 32'h0000_0002);
    endtask

    // the data SRAM keeps at most one request in flight since memory holds one item.
    initial begin : sram_model
        void'($urandom(32'hc489));
        data_sram_addr_ok = 1'b0;
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = '0;
        for (int i = 0; i < 256; i++) begin
            sram[i] = 32'h1357_0000 | (i * 32'h0101);
        end
        sram[4] = 32'hf28a_7bc3;  // bytes and halfwords of both signs.
        forever begin
            @(negedge clk);
            if (data_sram_data_ok) begin
                void'(resp_data.pop_front());
                void'(resp_wait.pop_front());
            end
            if (data_sram_req && data_sram_addr_ok) begin
                if (data_sram_wr) begin
                    sram[data_sram_addr[9:2]] = data_sram_wdata;
                    resp_data.push_back('0);
                end else begin
                    resp_data.push_back(sram[data_sram_addr[9:2]]);
                end
                resp_wait.push_back($urandom % 4);
            end
            @(posedge clk);
            #2;
            data_sram_addr_ok = ($urandom % 4) != 0;  // about one cycle in four refused.
            data_sram_data_ok = 1'b0;
            if (resp_data.size() != 0) begin
                if (resp_wait[0] == 0) begin
                    data_sram_data_ok = 1'b1;
                    data_sram_rdata   = resp_data[0];
                end else begin
                    resp_wait[0]--;
                end
            end
        end
    end

    task automatic check_retire();
        int i;
        i = n_checked;
        assert (i < names.size()) else begin
            $display("an instruction retired after the whole table, pc %h", wb_pc);
            errors++;
        end
        if (i < names.size()) begin
            assert (wb_pc === pcs[i]) else begin
                $display("error %s pc: expected %h, got %h", names[i], pcs[i], wb_pc);
                errors++;
            end
            assert (wb_rf_we === exp_we[i]) else begin
                $display("error %s we: expected %b, got %b", names[i], exp_we[i], wb_rf_we);
                errors++;
            end
            if (exp_we[i]) begin
                assert (wb_rf_waddr === exp_waddr[i]) else begin
                    $display("error %s waddr: expected %0d, got %0d",
                             names[i], exp_waddr[i], wb_rf_waddr);
                    errors++;
                end
                assert (wb_rf_wdata === exp_wdata[i]) else begin
                    $display("error %s wdata: expected %h, got %h",
                             names[i], exp_wdata[i], wb_rf_wdata);
                    errors++;
                end
            end
            n_checked++;
        end
    endtask

    always @(negedge clk) begin
        if (resetn === 1'b1 && wb_valid) begin
            check_retire();
        end
    end

    initial begin : watchdog
        int limit;
        int cycles;
        cycles = 0;
        wait (resetn === 1'b1);
        limit = 40 * names.size() + 100;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d instructions retired",
                 limit, n_checked, names.size());
        $display("%0d errors, %0d of %0d instructions checked", errors, n_checked, names.size());
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main_seq
        logic taken;
        resetn     = 1'b0;
        inst_valid = 1'b0;
        inst_word  = '0;
        inst_pc    = '0;
        build_table();
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;
        for (int i = 0; i < words.size(); i++) begin
            inst_valid = 1'b1;
            inst_word  = words[i];
            inst_pc    = pcs[i];
            do begin
                @(negedge clk);
                taken = inst_ready;
                @(posedge clk);
                #2;
            end while (!taken);
        end
        inst_valid = 1'b0;
        wait (n_checked == names.size());
        repeat (5) @(posedge clk);  // room for a stray extra retirement.
        $display("%0d errors, %0d of %0d instructions checked", errors, n_checked, names.size());
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/result_stage.sv
rtl/load_store_core.sv
dv/tb_load_store_core.sv

/* Bender.yml */
package:
  name: load_store_core

sources:
  - rtl/core_pkg.sv
  - rtl/reg_file.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/mem_stage.sv
  - rtl/result_stage.sv
  - rtl/load_store_core.sv
  - target: simulation
    files:
      - dv/tb_load_store_core.sv
